/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_mips_core
FILELIST ?= vlog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::if_id_t  if_id,
    input  mips_pkg::wb_t     wb,
    input  logic              flush,
    input  mips_pkg::id_ex_t  id_ex_cur,
    input  mips_pkg::ex_mem_t ex_mem_cur,
    output logic              stall,
    output mips_pkg::id_ex_t  id_ex
);

    import mips_pkg::*;

    logic [31:0] regs [32];
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    opcode_e     opcode;
    funct_e      funct;
    logic        uses_rs;
    logic        uses_rt;
    id_ex_t      id_next;

    assign rs     = if_id.inst[25:21];
    assign rt     = if_id.inst[20:16];
    assign rd     = if_id.inst[15:11];
    assign opcode = opcode_e'(if_id.inst[31:26]);
    assign funct  = funct_e'(if_id.inst[5:0]);

    ////////////////////////////////////////
    // register file

    always_ff @(posedge clk) begin
        if (wb.we && wb.dest != 5'd0)
            regs[wb.dest] <= wb.data;
    end

    // write-first read so writeback never needs a stall
    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0)
            return 32'd0;
        if (wb.we && wb.dest == idx)
            return wb.data;
        return regs[idx];
    endfunction

    ////////////////////////////////////////
    // decoder

    always_comb begin
        id_next         = '0;
        id_next.valid   = if_id.valid;
        id_next.pc4     = if_id.pc4;
        id_next.rs_data = read_reg(rs);
        id_next.rt_data = read_reg(rt);
        id_next.imm     = {{16{if_id.inst[15]}}, if_id.inst[15:0]};
        id_next.alu_op  = ALU_ADD;
        uses_rs         = 1'b1;
        uses_rt         = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                id_next.dest      = rd;
                id_next.reg_write = 1'b1;
                uses_rt           = 1'b1;
                case (funct)
                    FN_ADDU: id_next.alu_op = ALU_ADD;
                    FN_SUBU: id_next.alu_op = ALU_SUB;
                    FN_AND:  id_next.alu_op = ALU_AND;
                    FN_OR:   id_next.alu_op = ALU_OR;
                    FN_SLT:  id_next.alu_op = ALU_SLT;
                    FN_SYSCALL: begin
                        id_next.reg_write = 1'b0;
                        id_next.halt      = 1'b1;
                    end
                    default: id_next.reg_write = 1'b0;  // unsupported funct acts as nop
                endcase
            end
            OP_ADDIU, OP_LW: begin
                id_next.dest        = rt;
                id_next.alu_src_imm = 1'b1;
                id_next.reg_write   = 1'b1;
                id_next.load        = (opcode == OP_LW);
            end
            OP_SW: begin
                id_next.alu_src_imm = 1'b1;
                id_next.store       = 1'b1;
                uses_rt             = 1'b1;
            end
            OP_BEQ: begin
                id_next.alu_op = ALU_SUB;  // equal when the difference is zero
                id_next.branch = 1'b1;
                uses_rt        = 1'b1;
            end
            OP_J: begin
                id_next.imm  = {6'd0, if_id.inst[25:0]};
                id_next.jump = 1'b1;
                uses_rs      = 1'b0;
            end
            default: uses_rs = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // interlock

    function automatic logic pending(input logic [4:0] src);
        logic in_ex;
        logic in_mem;
        in_ex  = id_ex_cur.valid && id_ex_cur.reg_write && id_ex_cur.dest == src;
        in_mem = ex_mem_cur.valid && ex_mem_cur.reg_write && ex_mem_cur.dest == src;
        return (src != 5'd0) && (in_ex || in_mem);
    endfunction

    always_comb begin
        stall = if_id.valid && ((uses_rs && pending(rs)) || (uses_rt && pending(rt)));
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            id_ex.valid <= 1'b0;
        else if (stall || flush)
            id_ex.valid <= 1'b0;  // bubble
        else
            id_ex <= id_next;
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::id_ex_t  id_ex,
    output mips_pkg::ex_mem_t ex_mem,
    output logic              redirect,
    output logic [31:0]       redirect_pc
);

    import mips_pkg::*;

    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        taken;

    assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rt_data;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = id_ex.rs_data + op_b;
            ALU_SUB: alu_result = id_ex.rs_data - op_b;
            ALU_AND: alu_result = id_ex.rs_data & op_b;
            ALU_OR:  alu_result = id_ex.rs_data | op_b;
            ALU_SLT: alu_result = {31'd0, $signed(id_ex.rs_data) < $signed(op_b)};
            default: alu_result = id_ex.rs_data + op_b;
        endcase
    end

    ////////////////////////////////////////
    // branch and jump resolution

    assign taken    = id_ex.branch && (alu_result == 32'd0);
    assign redirect = id_ex.valid && (taken || id_ex.jump);

    assign redirect_pc = id_ex.jump ? {id_ex.pc4[31:28], id_ex.imm[25:0], 2'b00}
                                    : id_ex.pc4 + {id_ex.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= alu_result;
            ex_mem.rt_data    <= id_ex.rt_data;  // store data
            ex_mem.dest       <= id_ex.dest;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.load       <= id_ex.load;
            ex_mem.store      <= id_ex.store;
            ex_mem.halt       <= id_ex.halt;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             redirect,
    input  logic [31:0]      redirect_pc,
    input  logic             halted,
    input  logic [31:0]      inst,
    output logic [31:0]      inst_addr,
    output mips_pkg::if_id_t if_id
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;

    assign pc_plus4  = pc + 32'd4;
    assign inst_addr = pc;

    // redirect wins over stall, the stalled instruction is squashed anyway
    assign pc_next = redirect          ? redirect_pc :
                     (stall || halted) ? pc          : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= RESET_PC;
            if_id.valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (redirect || halted) begin
                if_id.valid <= 1'b0;
            end else if (!stall) begin
                if_id.valid <= 1'b1;
                if_id.pc4   <= pc_plus4;
                if_id.inst  <= inst;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::ex_mem_t ex_mem,
    input  logic [31:0]       mem_rdata,
    output logic [31:0]       mem_addr,
    output logic [31:0]       mem_wdata,
    output logic              mem_write_en,
    output mips_pkg::wb_t     wb,
    output logic              halted
);

    // data port, read is combinational and the write lands at the edge
    assign mem_addr     = ex_mem.alu_result;
    assign mem_wdata    = ex_mem.rt_data;
    assign mem_write_en = ex_mem.valid && ex_mem.store;

    ////////////////////////////////////////
    // MEM/WB register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.we  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb.we   <= ex_mem.valid && ex_mem.reg_write;
            wb.dest <= ex_mem.dest;
            wb.data <= ex_mem.load ? mem_rdata : ex_mem.alu_result;
            if (ex_mem.valid && ex_mem.halt)
                halted <= 1'b1;  // sticky until reset
        end
    end

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] inst,
    input  logic [31:0] mem_rdata,
    output logic [31:0] inst_addr,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        mem_write_en,
    output logic        halted
);

    import mips_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_t         wb;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted),
        .inst       (inst),
        .inst_addr  (inst_addr),
        .if_id      (if_id)
    );

    decode_stage i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_id     (if_id),
        .wb        (wb),
        .flush     (redirect),  // squash the instruction behind a taken branch
        .id_ex_cur (id_ex),
        .ex_mem_cur(ex_mem),
        .stall     (stall),
        .id_ex     (id_ex)
    );

    execute_stage i_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    memory_stage i_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_mem      (ex_mem),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_write_en(mem_write_en),
        .wb          (wb),
        .halted      (halted)
    );

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////
    // instruction encodings

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SYSCALL = 6'h0c,  // used as halt
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    ////////////////////////////////////////
    // pipeline bundles

    typedef struct packed {
        logic        valid;
        logic [31:0] pc4;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc4;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] imm;          // jump index for J
        logic [4:0]  dest;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        logic        reg_write;
        logic        load;
        logic        store;
        logic        branch;
        logic        jump;
        logic        halt;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_result;
        logic [31:0] rt_data;
        logic [4:0]  dest;
        logic        reg_write;
        logic        load;
        logic        store;
        logic        halt;
    } ex_mem_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* test/mips_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_sva #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] inst_addr,
    input logic [31:0] mem_addr,
    input logic        mem_write_en,
    input logic        halted,
    input logic        redirect,
    input logic [31:0] redirect_pc,
    input logic        if_id_valid,
    input logic        id_ex_valid
);

    localparam logic [31:0] POISON_BEQ = 32'd64;  // store behind the taken beq
    localparam logic [31:0] POISON_J   = 32'd68;  // store behind the jump

    int unsigned failures = 0;

    // the edge that samples rst_n low has already reset the state
    reset_state: assert property (@(posedge clk)
        !rst_n |=> inst_addr == RESET_PC && !mem_write_en && !halted)
        else begin
            $error("core state wrong during or just after reset");
            failures++;
        end

    squashed_store: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write_en |-> mem_addr != POISON_BEQ && mem_addr != POISON_J)
        else begin
            $error("store from a squashed slot reached the data port");
            failures++;
        end

    fetch_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> inst_addr == $past(redirect_pc) && !if_id_valid && !id_ex_valid)
        else begin
            $error("redirect did not load the target or squash the younger slots");
            failures++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && $stable(inst_addr))
        else begin
            $error("halted dropped or fetch kept moving after halt");
            failures++;
        end

endmodule

bind mips_core mips_core_sva #(.RESET_PC(RESET_PC)) i_sva (
    .clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .mem_addr(mem_addr),
    .mem_write_en(mem_write_en), .halted(halted), .redirect(redirect),
    .redirect_pc(redirect_pc), .if_id_valid(if_id.valid), .id_ex_valid(id_ex.valid)
);

`default_nettype wire

/* test/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] RESET_PC       = 32'h0000_0000;
    localparam int          RESET_CYCLES   = 8;
    localparam int          PROG_LEN       = 24;
    localparam int          N_STORES       = 8;
    // one issue plus up to 2 interlock cycles per instruction and a margin
    localparam int          TIMEOUT_CYCLES = PROG_LEN * 3 + RESET_CYCLES + 320;
    localparam logic [5:0]  OPC_LW         = 6'h23;
    localparam logic [5:0]  OPC_SW         = 6'h2b;
    localparam logic [5:0]  OPC_ADDIU      = 6'h09;
    localparam logic [5:0]  OPC_BEQ        = 6'h04;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] mem_rdata;
    logic [31:0] inst_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_write_en;
    logic        halted;
    logic [31:0] imem_offset;
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] exp_addr [N_STORES];
    logic [31:0] exp_data [N_STORES];
    logic [15:0] lfsr;
    int          stores_seen = 0;
    int          stores_at_halt;
    int          cycles = 0;

    mips_core #(.RESET_PC(RESET_PC)) i_dut (
        .clk(clk), .rst_n(rst_n), .inst(inst), .mem_rdata(mem_rdata),
        .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_write_en(mem_write_en), .halted(halted)
    );

    assign imem_offset = inst_addr - RESET_PC;
    assign inst        = imem[imem_offset[7:2]];  // same-cycle fetch
    assign mem_rdata   = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_write_en)
            dmem[mem_addr[7:2]] <= mem_wdata;
    end

    function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_format(input int idx);
        logic [31:0] target;
        target = RESET_PC + 32'(idx) * 32'd4;
        return {6'h02, target[27:2]};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic random_word(output logic [31:0] w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    ////////////////////////////////////////
    // program, data and expected stores

    task automatic load_memories();
        int i;
        for (i = 0; i < 64; i++) begin
            imem[i] = {20'd0, 6'(i), 6'd0};  // sll type filler that decodes as nop
            dmem[i] = 32'hd00d_0000 | 32'(i);
        end
        lfsr = 16'd78;
        for (i = 0; i < 4; i++)
            random_word(dmem[i]);
        imem[0]  = i_format(OPC_LW, 5'd0, 5'd1, 16'd0);
        imem[1]  = i_format(OPC_LW, 5'd0, 5'd2, 16'd4);
        imem[2]  = r_format(6'h21, 5'd3, 5'd1, 5'd2);        // addu with a load-use hazard
        imem[3]  = i_format(OPC_LW, 5'd0, 5'd9, 16'd8);
        imem[4]  = i_format(OPC_LW, 5'd0, 5'd10, 16'd12);
        imem[5]  = r_format(6'h23, 5'd4, 5'd9, 5'd10);       // subu
        imem[6]  = r_format(6'h24, 5'd5, 5'd3, 5'd4);        // and right behind its producer
        imem[7]  = r_format(6'h25, 5'd6, 5'd3, 5'd4);        // or
        imem[8]  = r_format(6'h2a, 5'd7, 5'd1, 5'd2);        // slt
        imem[9]  = i_format(OPC_ADDIU, 5'd7, 5'd8, 16'hff9c);  // -100
        imem[10] = i_format(OPC_ADDIU, 5'd0, 5'd11, 16'd16);   // store base
        for (i = 0; i < 6; i++)
            imem[11 + i] = i_format(OPC_SW, 5'd11, 5'(3 + i), 16'(4 * i));
        imem[17] = i_format(OPC_BEQ, 5'd1, 5'd1, 16'd1);     // always taken
        imem[18] = i_format(OPC_SW, 5'd0, 5'd1, 16'd64);     // poison
        imem[19] = i_format(OPC_SW, 5'd11, 5'd9, 16'd24);
        imem[20] = j_format(22);
        imem[21] = i_format(OPC_SW, 5'd0, 5'd1, 16'd68);     // poison
        imem[22] = i_format(OPC_SW, 5'd11, 5'd10, 16'd28);
        imem[23] = 32'h0000_000c;                            // syscall used as halt
    endtask

    task automatic build_expected();
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] less;
        int          i;
        sum  = dmem[0] + dmem[1];
        diff = dmem[2] - dmem[3];
        less = ($signed(dmem[0]) < $signed(dmem[1])) ? 32'd1 : 32'd0;
        exp_data[0] = sum;
        exp_data[1] = diff;
        exp_data[2] = sum & diff;
        exp_data[3] = sum | diff;
        exp_data[4] = less;
        exp_data[5] = less - 32'd100;
        exp_data[6] = dmem[2];
        exp_data[7] = dmem[3];
        for (i = 0; i < N_STORES; i++)
            exp_addr[i] = 32'd16 + 32'(i) * 32'd4;
    endtask

    task automatic abort_run(input string reason);
        $display("%0t: %s", $time, reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            $display("FAILED %0t %s got %08h expected %08h", $time, name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////
    // clock, monitors and run

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            abort_run("timeout, the core never halted");
    end

    // the write pulse is stable between rising edges
    always @(negedge clk) begin
        if (i_dut.i_sva.failures != 0) begin
            abort_run("a bound assertion on the core failed");
        end else if (rst_n && mem_write_en) begin
            if (stores_seen >= N_STORES) begin
                abort_run("more stores than the program holds");
            end else begin
                check_value("mem_addr", mem_addr, exp_addr[stores_seen]);
                check_value("mem_wdata", mem_wdata, exp_data[stores_seen]);
                stores_seen++;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        load_memories();
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        do
            @(negedge clk);
        while (!halted);
        stores_at_halt = stores_seen;
        repeat (4) @(negedge clk);  // let the halt assertions run a few cycles
        if (stores_at_halt == N_STORES && stores_seen == N_STORES &&
            i_dut.i_sva.failures == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("store count at halt does not match the program");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_core.sv
test/mips_core_sva.sv
test/tb_mips_core.sv
